// ==== debug_pkg.sv ====
package debug_pkg;

	// Host bus
	typedef logic [15:0] host_addr_t;
	typedef logic [7:0] byte_t;

	// Index into the special-function window
	typedef logic [2:0] reg_offset_t;

	// Frame-buffer side
	typedef logic [19:0] fb_addr_t;
	typedef logic [15:0] fb_data_t;

	// Window placement, a 4 KB block at the base
	localparam host_addr_t DEF_SPECIAL_BASE = 16'h6000;
	localparam int WINDOW_BITS = 12;

	// Register offsets inside the window
	localparam reg_offset_t OFS_ADDR0 = 3'd0;
	localparam reg_offset_t OFS_ADDR1 = 3'd1;
	localparam reg_offset_t OFS_ADDR2 = 3'd2;
	localparam reg_offset_t OFS_DATA0 = 3'd4;
	localparam reg_offset_t OFS_DATA1 = 3'd5;
	localparam reg_offset_t OFS_CTRL = 3'd6;
	localparam reg_offset_t OFS_SCAN = 3'd7;

	// Control register bits
	localparam int CTRL_LOAD_BIT = 6;
	localparam int CTRL_BUSY_BIT = 7;

	// Bits moved per scan exchange
	localparam int SCAN_BITS = 8;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_SHIFT,
		SCAN_DONE
	} scan_state_t;

endpackage

// ==== reg_bus_if.sv ====
// Decoded register access, one cycle per hit inside the window
interface reg_bus_if;

	debug_pkg::reg_offset_t offset;
	debug_pkg::byte_t wdata;
	logic wr;
	logic rd;

	modport decoder (
		output offset,
		output wdata,
		output wr,
		output rd
	);

	modport regs (
		input offset,
		input wdata,
		input wr,
		input rd
	);

endinterface

// ==== scan_if.sv ====
// Register file to scan engine
interface scan_if;

	logic start;
	debug_pkg::byte_t tx_byte;
	logic busy;
	logic done;
	debug_pkg::byte_t rx_byte;

	modport master (
		output start,
		output tx_byte,
		input busy,
		input done,
		input rx_byte
	);

	modport engine (
		input start,
		input tx_byte,
		output busy,
		output done,
		output rx_byte
	);

endinterface

// ==== bus_decode.sv ====
module bus_decode #(
	parameter debug_pkg::host_addr_t SPECIAL_BASE = debug_pkg::DEF_SPECIAL_BASE
) (
	input logic clkDebug,
	input logic n_reset,
	input debug_pkg::host_addr_t host_addr,
	input debug_pkg::byte_t host_wdata,
	input logic host_wr,
	input logic host_rd,
	reg_bus_if.decoder bus
);

	localparam int AW = $bits(debug_pkg::host_addr_t);
	localparam int WL = debug_pkg::WINDOW_BITS;

	logic hit;

	// Only the bits above the window size take part in the match
	assign hit = host_addr[AW-1:WL] == SPECIAL_BASE[AW-1:WL];

	// Strobes are qualified by the window hit
	always_ff @(posedge clkDebug, negedge n_reset) begin
		if (!n_reset) begin
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
		end else begin
			bus.wr <= host_wr & hit;
			bus.rd <= host_rd & hit;
		end
	end

	// Offset and data are only looked at alongside a strobe
	always_ff @(posedge clkDebug) begin
		bus.offset <= debug_pkg::reg_offset_t'(host_addr);
		bus.wdata <= host_wdata;
	end

endmodule

// ==== debug_regs.sv ====
module debug_regs (
	input logic clkDebug,
	input logic n_reset,
	reg_bus_if.regs bus,
	scan_if.master scan,
	output debug_pkg::byte_t rdata,
	output logic rvalid,
	output logic fire,
	output debug_pkg::fb_addr_t cur_addr,
	output debug_pkg::fb_data_t cur_data,
	output logic load
);

	debug_pkg::byte_t addr0, addr1, addr2;
	debug_pkg::byte_t data0, data1;
	debug_pkg::byte_t ctrl;
	debug_pkg::byte_t rx_byte;
	debug_pkg::byte_t rd_mux;
	debug_pkg::fb_addr_t addr_now;
	debug_pkg::fb_addr_t addr_inc;

	// Address is 20 bits, so only the low nibble of addr2 belongs to it
	assign addr_now = {addr2[3:0], addr1, addr0};
	assign addr_inc = addr_now + 20'd1;
	assign cur_data = {data1, data0};

	always_ff @(posedge clkDebug, negedge n_reset) begin
		if (!n_reset) begin
			addr0 <= '0;
			addr1 <= '0;
			addr2 <= '0;
			data0 <= '0;
			data1 <= '0;
			ctrl <= '0;
			rx_byte <= '0;
			scan.tx_byte <= '0;
			scan.start <= 1'b0;
			fire <= 1'b0;
		end else begin
			fire <= 1'b0;
			scan.start <= 1'b0;
			if (bus.wr) begin
				case (bus.offset)
					debug_pkg::OFS_ADDR0: addr0 <= bus.wdata;
					debug_pkg::OFS_ADDR1: addr1 <= bus.wdata;
					debug_pkg::OFS_ADDR2: addr2 <= bus.wdata;
					debug_pkg::OFS_DATA0: data0 <= bus.wdata;
					debug_pkg::OFS_DATA1: begin
						// Upper data byte fires the request and steps the address
						data1 <= bus.wdata;
						fire <= 1'b1;
						{addr2[3:0], addr1, addr0} <= addr_inc;
					end
					debug_pkg::OFS_CTRL: ctrl <= bus.wdata;
					debug_pkg::OFS_SCAN: begin
						scan.tx_byte <= bus.wdata;
						scan.start <= 1'b1;
					end
					default: ;
				endcase
			end
			// Keep the received byte once the exchange has finished
			if (scan.done)
				rx_byte <= scan.rx_byte;
		end
	end

	// Snapshot of the address before the increment
	always_ff @(posedge clkDebug) begin
		if (bus.wr && bus.offset == debug_pkg::OFS_DATA1)
			cur_addr <= addr_now;
	end

	always_comb begin
		rd_mux = '0;
		case (bus.offset)
			debug_pkg::OFS_ADDR0: rd_mux = addr0;
			debug_pkg::OFS_ADDR1: rd_mux = addr1;
			debug_pkg::OFS_ADDR2: rd_mux = addr2;
			debug_pkg::OFS_DATA0: rd_mux = data0;
			debug_pkg::OFS_DATA1: rd_mux = data1;
			debug_pkg::OFS_CTRL: begin
				rd_mux = ctrl;
				rd_mux[debug_pkg::CTRL_BUSY_BIT] = scan.busy;
			end
			debug_pkg::OFS_SCAN: rd_mux = rx_byte;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge clkDebug, negedge n_reset) begin
		if (!n_reset) begin
			rdata <= '0;
			rvalid <= 1'b0;
			load <= 1'b0;
		end else begin
			rvalid <= bus.rd;
			if (bus.rd)
				rdata <= rd_mux;
			load <= ctrl[debug_pkg::CTRL_LOAD_BIT];
		end
	end

endmodule

// ==== fb_request.sv ====
module fb_request (
	input logic clkDebug,
	input logic n_reset,
	input logic fire,
	input debug_pkg::fb_addr_t cur_addr,
	input debug_pkg::fb_data_t cur_data,
	output debug_pkg::fb_addr_t fb_addr,
	output debug_pkg::fb_data_t fb_data,
	output logic fb_req
);

	// Output stage toward the frame buffer
	// Address and data stay put until the next request replaces them
	always_ff @(posedge clkDebug, negedge n_reset) begin
		if (!n_reset) begin
			fb_addr <= '0;
			fb_data <= '0;
		end else if (fire) begin
			fb_addr <= cur_addr;
			fb_data <= cur_data;
		end
	end

	// One-cycle request, lined up with the captured payload
	always_ff @(posedge clkDebug, negedge n_reset) begin
		if (!n_reset)
			fb_req <= 1'b0;
		else
			fb_req <= fire;
	end

endmodule

// ==== scan_chain.sv ====
module scan_chain (
	input logic clkDebug,
	input logic n_reset,
	scan_if.engine scan,
	output logic scan_shift,
	input logic scan_din,
	output logic scan_dout
);

	localparam logic [2:0] LAST_BIT = 3'(debug_pkg::SCAN_BITS - 1);

	debug_pkg::scan_state_t state;
	logic [2:0] cnt;
	debug_pkg::byte_t sr;

	always_ff @(posedge clkDebug, negedge n_reset) begin
		if (!n_reset) begin
			state <= debug_pkg::SCAN_IDLE;
			cnt <= '0;
			sr <= '0;
		end else begin
			case (state)
				debug_pkg::SCAN_SHIFT: begin
					// MSB leaves on dout, din enters at the LSB
					sr <= {sr[6:0], scan_din};
					cnt <= cnt + 3'd1;
					if (cnt == LAST_BIT)
						state <= debug_pkg::SCAN_DONE;
				end
				default: begin
					// Idle and done both accept a new start
					if (scan.start) begin
						sr <= scan.tx_byte;
						cnt <= '0;
						state <= debug_pkg::SCAN_SHIFT;
					end else begin
						state <= debug_pkg::SCAN_IDLE;
					end
				end
			endcase
		end
	end

	assign scan_shift = state == debug_pkg::SCAN_SHIFT;
	assign scan_dout = sr[7];

	assign scan.busy = state == debug_pkg::SCAN_SHIFT;
	// Done lasts the single cycle after the last shift
	assign scan.done = state == debug_pkg::SCAN_DONE;
	assign scan.rx_byte = sr;

endmodule

// ==== debug_top.sv ====
module debug_top #(
	parameter debug_pkg::host_addr_t SPECIAL_BASE = debug_pkg::DEF_SPECIAL_BASE
) (
	input logic clkDebug,
	input logic n_reset,
	// Host bus
	input debug_pkg::host_addr_t host_addr,
	input debug_pkg::byte_t host_wdata,
	input logic host_wr,
	input logic host_rd,
	output debug_pkg::byte_t host_rdata,
	output logic host_rvalid,
	// Frame-buffer requests
	output debug_pkg::fb_addr_t fb_addr,
	output debug_pkg::fb_data_t fb_data,
	output logic fb_req,
	// Debug scan chain
	output logic scan_load,
	output logic scan_shift,
	input logic scan_din,
	output logic scan_dout
);

	logic fire;
	debug_pkg::fb_addr_t cur_addr;
	debug_pkg::fb_data_t cur_data;

	reg_bus_if rbus ();
	scan_if sbus ();

	bus_decode #(
		.SPECIAL_BASE(SPECIAL_BASE)
	) u_decode (
		.clkDebug(clkDebug),
		.n_reset(n_reset),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_wr(host_wr),
		.host_rd(host_rd),
		.bus(rbus.decoder)
	);

	debug_regs u_regs (
		.clkDebug(clkDebug),
		.n_reset(n_reset),
		.bus(rbus.regs),
		.scan(sbus.master),
		.rdata(host_rdata),
		.rvalid(host_rvalid),
		.fire(fire),
		.cur_addr(cur_addr),
		.cur_data(cur_data),
		.load(scan_load)
	);

	fb_request u_fb (
		.clkDebug(clkDebug),
		.n_reset(n_reset),
		.fire(fire),
		.cur_addr(cur_addr),
		.cur_data(cur_data),
		.fb_addr(fb_addr),
		.fb_data(fb_data),
		.fb_req(fb_req)
	);

	scan_chain u_scan (
		.clkDebug(clkDebug),
		.n_reset(n_reset),
		.scan(sbus.engine),
		.scan_shift(scan_shift),
		.scan_din(scan_din),
		.scan_dout(scan_dout)
	);

endmodule

// ==== debug_props.sv ====
module debug_props (
	input logic clkDebug,
	input logic n_reset,
	input logic host_rd,
	input logic host_rvalid,
	input logic fb_req,
	input logic scan_shift
);

	// A request is always a single-cycle pulse
	property fb_req_single;
		@(posedge clkDebug) disable iff (!n_reset)
			fb_req |=> !fb_req;
	endproperty

	// One exchange moves eight bits, so shift never lasts longer
	property shift_bounded;
		@(posedge clkDebug) disable iff (!n_reset)
			$rose(scan_shift) |-> ##[1:8] !scan_shift;
	endproperty

	// Read data comes back two cycles after the host strobe
	property rvalid_after_read;
		@(posedge clkDebug) disable iff (!n_reset)
			host_rvalid |-> $past(host_rd, 2);
	endproperty

	a_fb_req_single: assert property (fb_req_single)
		else $error("fb_req high on two consecutive cycles");
	a_shift_bounded: assert property (shift_bounded)
		else $error("scan_shift high for more than 8 cycles");
	a_rvalid_after_read: assert property (rvalid_after_read)
		else $error("host_rvalid without a read two cycles earlier");

endmodule

bind debug_top debug_props u_props (
	.clkDebug(clkDebug),
	.n_reset(n_reset),
	.host_rd(host_rd),
	.host_rvalid(host_rvalid),
	.fb_req(fb_req),
	.scan_shift(scan_shift)
);

// ==== tb_debug.sv ====
module tb_debug;

	localparam int K_WR = 0;
	localparam int K_RD = 1;
	localparam int K_OUT = 2;
	localparam int K_FB = 3;
	localparam int K_SCAN = 4;
	localparam int K_LOAD = 5;
	localparam int TIMEOUT = 50;
	localparam logic [15:0] BASE = 16'h6000;

	typedef struct {
		string name;
		int kind;
		logic [2:0] ofs;
		logic [7:0] value;
		logic [7:0] expected;
	} step_t;

	logic clkDebug = 1'b0;
	logic n_reset;
	logic [15:0] host_addr;
	logic [7:0] host_wdata;
	logic host_wr;
	logic host_rd;
	logic [7:0] host_rdata;
	logic host_rvalid;
	logic [19:0] fb_addr;
	logic [15:0] fb_data;
	logic fb_req;
	logic scan_load;
	logic scan_shift;
	logic scan_din;
	logic scan_dout;

	step_t steps[$];
	integer seed = 32'h682cd876;
	logic [7:0] din_byte;
	logic [7:0] dout_rec;
	int shift_cnt;
	logic [19:0] exp_addr;
	logic [7:0] exp_data0;

	debug_top #(
		.SPECIAL_BASE(BASE)
	) DUT (
		.clkDebug(clkDebug),
		.n_reset(n_reset),
		.host_addr(host_addr),
		.host_wdata(host_wdata),
		.host_wr(host_wr),
		.host_rd(host_rd),
		.host_rdata(host_rdata),
		.host_rvalid(host_rvalid),
		.fb_addr(fb_addr),
		.fb_data(fb_data),
		.fb_req(fb_req),
		.scan_load(scan_load),
		.scan_shift(scan_shift),
		.scan_din(scan_din),
		.scan_dout(scan_dout)
	);

	always #4 clkDebug = ~clkDebug;

	// Scan chain model that records dout and counts shifts
	always @(negedge clkDebug) begin
		if (scan_shift) begin
			dout_rec = {dout_rec[6:0], scan_dout};
			shift_cnt = shift_cnt + 1;
		end
	end

	// Next din bit is ready before the edge that captures it
	always @(posedge clkDebug) begin
		if (shift_cnt < 8)
			scan_din <= din_byte[7 - shift_cnt];
	end

	task automatic fail_value(string name, int exp, int act);
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic fail_text(string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic add(string name, int kind, logic [2:0] ofs, logic [7:0] value,
			logic [7:0] expected);
		step_t s;
		s.name = name;
		s.kind = kind;
		s.ofs = ofs;
		s.value = value;
		s.expected = expected;
		steps.push_back(s);
	endtask

	task automatic bus_write(logic [15:0] a, logic [7:0] d);
		@(posedge clkDebug);
		host_addr <= a;
		host_wdata <= d;
		host_wr <= 1'b1;
		@(posedge clkDebug);
		host_wr <= 1'b0;
	endtask

	task automatic bus_read(logic [15:0] a, output logic [7:0] d);
		int n;
		@(posedge clkDebug);
		host_addr <= a;
		host_rd <= 1'b1;
		@(posedge clkDebug);
		host_rd <= 1'b0;
		n = 0;
		while (!host_rvalid && n < TIMEOUT) begin
			@(negedge clkDebug);
			n++;
		end
		if (!host_rvalid)
			fail_text($sformatf("No read response at address %h", a));
		d = host_rdata;
	endtask

	task automatic read_outside(string name, logic [15:0] a);
		@(posedge clkDebug);
		host_addr <= a;
		host_rd <= 1'b1;
		@(posedge clkDebug);
		host_rd <= 1'b0;
		for (int i = 0; i < 6; i++) begin
			@(negedge clkDebug);
			assert (!host_rvalid)
				else fail_text({name, ": read outside the window gave host_rvalid"});
		end
	endtask

	task automatic run_fb(step_t s);
		int hits;
		int at;
		logic [19:0] addr_seen;
		hits = 0;
		at = 0;
		addr_seen = '0;
		bus_write(BASE | 16'(s.ofs), s.value);
		for (int i = 1; i <= 6; i++) begin
			@(negedge clkDebug);
			if (fb_req) begin
				hits++;
				at = i;
				addr_seen = fb_addr;
			end
		end
		assert (hits == 1) else fail_value({s.name, " pulses"}, 1, hits);
		assert (at == 3) else fail_value({s.name, " delay"}, 3, at);
		assert (addr_seen == exp_addr)
			else fail_value({s.name, " addr"}, int'(exp_addr), int'(addr_seen));
		assert (fb_data == {s.value, exp_data0})
			else fail_value({s.name, " data"}, int'({s.value, exp_data0}), int'(fb_data));
		exp_addr = exp_addr + 20'd1;
	endtask

	task automatic run_scan(step_t s);
		int n;
		logic [7:0] d;
		din_byte = 8'($random(seed));
		shift_cnt = 0;
		dout_rec = '0;
		bus_write(BASE | 16'(s.ofs), s.value);
		n = 0;
		while (!scan_shift && n < TIMEOUT) begin
			@(negedge clkDebug);
			n++;
		end
		if (!scan_shift)
			fail_text({s.name, ": scan_shift never rose"});
		// Second start lands while shifting and must be dropped
		bus_write(BASE | 16'(s.ofs), ~s.value);
		bus_read(BASE | 16'(debug_pkg::OFS_CTRL), d);
		assert (d[7]) else fail_value({s.name, " busy"}, 'h80, int'(d));
		n = 0;
		while (scan_shift && n < TIMEOUT) begin
			@(negedge clkDebug);
			n++;
		end
		if (scan_shift)
			fail_text({s.name, ": scan_shift never fell"});
		for (int i = 0; i < 6; i++) begin
			@(negedge clkDebug);
			assert (!scan_shift) else fail_text({s.name, ": second scan was not dropped"});
		end
		assert (shift_cnt == 8) else fail_value({s.name, " shifts"}, 8, shift_cnt);
		assert (dout_rec == s.value)
			else fail_value({s.name, " dout"}, int'(s.value), int'(dout_rec));
		bus_read(BASE | 16'(s.ofs), d);
		assert (d == din_byte) else fail_value({s.name, " rx"}, int'(din_byte), int'(d));
	endtask

	task automatic run_load(step_t s);
		int n;
		logic [7:0] d;
		bus_write(BASE | 16'(debug_pkg::OFS_CTRL), s.value);
		n = 0;
		while (scan_load != s.expected[0] && n < TIMEOUT) begin
			@(negedge clkDebug);
			n++;
		end
		assert (scan_load == s.expected[0])
			else fail_value({s.name, " load"}, int'(s.expected[0]), int'(scan_load));
		bus_read(BASE | 16'(debug_pkg::OFS_CTRL), d);
		assert (d == s.value) else fail_value({s.name, " ctrl"}, int'(s.value), int'(d));
	endtask

	task automatic run_step(step_t s);
		logic [7:0] d;
		case (s.kind)
			K_WR: begin
				bus_write(BASE | 16'(s.ofs), s.value);
				case (s.ofs)
					3'd0: exp_addr[7:0] = s.value;
					3'd1: exp_addr[15:8] = s.value;
					3'd2: exp_addr[19:16] = s.value[3:0];
					3'd4: exp_data0 = s.value;
					3'd5: exp_addr = exp_addr + 20'd1;
					default: ;
				endcase
			end
			K_RD: begin
				bus_read(BASE | 16'(s.ofs), d);
				assert (d == s.expected) else fail_value(s.name, int'(s.expected), int'(d));
			end
			K_OUT: read_outside(s.name, 16'h7000 | 16'(s.ofs));
			K_FB: run_fb(s);
			K_SCAN: run_scan(s);
			default: run_load(s);
		endcase
	endtask

	initial begin
		n_reset = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		host_wr = 1'b0;
		host_rd = 1'b0;
		scan_din = 1'b0;
		din_byte = '0;
		dout_rec = '0;
		shift_cnt = 8;
		exp_addr = '0;
		exp_data0 = '0;
		repeat (10) @(posedge clkDebug);
		n_reset <= 1'b1;
		@(negedge clkDebug);
		assert (!fb_req && !scan_shift && !scan_load && !scan_dout && !host_rvalid)
			else fail_text("Outputs not idle after reset");

		for (int i = 0; i < 8; i++)
			add($sformatf("reset_ofs%0d", i), K_RD, 3'(i), 8'h00, 8'h00);
		add("outside_read", K_OUT, 3'd0, 8'h00, 8'h00);
		add("wr_addr0", K_WR, 3'd0, 8'ha5, 8'h00);
		add("wr_addr1", K_WR, 3'd1, 8'h5a, 8'h00);
		add("wr_addr2", K_WR, 3'd2, 8'h0c, 8'h00);
		add("wr_data0", K_WR, 3'd4, 8'hc3, 8'h00);
		add("rd_addr0", K_RD, 3'd0, 8'h00, 8'ha5);
		add("rd_addr1", K_RD, 3'd1, 8'h00, 8'h5a);
		add("rd_addr2", K_RD, 3'd2, 8'h00, 8'h0c);
		add("rd_data0", K_RD, 3'd4, 8'h00, 8'hc3);
		add("wr_data1", K_WR, 3'd5, 8'h3c, 8'h00);
		add("rd_data1", K_RD, 3'd5, 8'h00, 8'h3c);
		add("rd_addr0_inc", K_RD, 3'd0, 8'h00, 8'ha6);
		add("rd_reserved", K_RD, 3'd3, 8'h00, 8'h00);
		add("fb_addr0", K_WR, 3'd0, 8'hff, 8'h00);
		add("fb_addr1", K_WR, 3'd1, 8'hff, 8'h00);
		add("fb_addr2", K_WR, 3'd2, 8'h03, 8'h00);
		add("fb_data0", K_WR, 3'd4, 8'h34, 8'h00);
		add("fb_write", K_FB, 3'd5, 8'h12, 8'h00);
		add("carry_addr0", K_RD, 3'd0, 8'h00, 8'h00);
		add("carry_addr1", K_RD, 3'd1, 8'h00, 8'h00);
		add("carry_addr2", K_RD, 3'd2, 8'h00, 8'h04);
		add("scan_a", K_SCAN, 3'd7, 8'h96, 8'h00);
		add("scan_b", K_SCAN, 3'd7, 8'h3b, 8'h00);
		add("load_on", K_LOAD, 3'd6, 8'h40, 8'h01);
		add("load_off", K_LOAD, 3'd6, 8'h00, 8'h00);

		foreach (steps[i])
			run_step(steps[i]);

		$display("=== PASS ===");
		$finish;
	end

endmodule

// ==== files.f ====
debug_pkg.sv
reg_bus_if.sv
scan_if.sv
bus_decode.sv
debug_regs.sv
fb_request.sv
scan_chain.sv
debug_top.sv
debug_props.sv
tb_debug.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_debug -o sim_debug

# The simulator may exit non-zero on failure, the log decides
set +e
./obj_dir/sim_debug 2>&1 | tee sim.log
set -e

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed"
	exit 1
fi

if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation passed"
